// File: ps2_kbd.f
hw/ps2_pkg.sv
hw/ps2_ifs.sv
hw/ps2_frame_rx.sv
hw/ps2_scan_decoder.sv
hw/ps2_event_fifo.sv
hw/ps2_apb_regs.sv
hw/ps2_kbd_top.sv
verif/ps2_kbd_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PS/2 keyboard receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ps2_kbd_tb -f ps2_kbd.f -o sim_ps2_kbd

output=$(./obj_dir/sim_ps2_kbd)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi

// File: verif/ps2_kbd_tb.sv
`timescale 1ns/1ps

module ps2_kbd_tb;

    // 60 frames of 11 bits at 40 clocks of 20 ns, plus 20 us margin
    localparam time WATCHDOG_NS = 60 * 11 * 40 * 20 + 20000;

    logic               clk;
    logic               rst;
    logic               ps2_clk;
    logic               ps2_data;
    ps2_pkg::apb_addr_t paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    ps2_pkg::apb_data_t pwdata;
    ps2_pkg::apb_data_t prdata;
    logic               pready;
    logic               pslverr;
    logic               irq;

    integer seed;
    int     errors;
    int     pass_count;
    int     fail_count;

    ps2_kbd_top #(.FIFO_DEPTH(8), .IDLE_TIMEOUT(2000)) dut0 (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_data(ps2_data),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    // 20 ns system clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Key event word {release, extended, code}
    function automatic logic [31:0] key_word(input logic rel, input logic ext,
                                             input logic [7:0] code);
        key_word = {22'd0, rel, ext, code};
    endfunction

    // Random make code, never a prefix byte
    task automatic next_code(output logic [7:0] code);
        code = 8'($random(seed));
        while (code == 8'hE0 || code == 8'hF0) begin
            code = 8'($random(seed));
        end
    endtask

    task automatic apb_write(input ps2_pkg::apb_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Samples prdata and pslverr mid access phase
    task automatic apb_read(input ps2_pkg::apb_addr_t addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Keyboard model, frame bits LSB first, 20 clk half periods
    task automatic send_frame(input logic [7:0] code, input logic par_ok,
                              input logic stop, input int nbits);
        logic [10:0] frame;
        logic        par;
        // Odd parity over data plus parity bit
        par   = par_ok ? ~(^code) : ^code;
        frame = {stop, par, code, 1'b0};
        for (int i = 0; i < nbits; i++) begin
            // Data moves while ps2_clk is high
            @(posedge clk);
            ps2_data <= frame[i];
            repeat (10) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (20) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (9) @(posedge clk);
        end
        @(posedge clk);
        ps2_data <= 1'b1;
        repeat (20) @(posedge clk);
    endtask

    // Poll STATUS until the masked field matches
    task automatic wait_for_status(input string what, input logic [31:0] mask,
                                   input logic [31:0] value, input int max_polls);
        logic [31:0] st;
        logic        err;
        int          n;
        n = 0;
        apb_read(ps2_pkg::REG_STATUS, st, err);
        while ((st & mask) != value && n < max_polls) begin
            apb_read(ps2_pkg::REG_STATUS, st, err);
            n++;
        end
        assert ((st & mask) == value) else begin
            $display("Timed out at %0t waiting for %s in STATUS", $time, what);
            errors++;
        end
    endtask

    task automatic wait_irq(input logic value, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (irq !== value && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (irq === value) else begin
            $display("Timed out at %0t waiting for irq to become %b", $time, value);
            errors++;
        end
    endtask

    // One event expected, then an empty queue
    task automatic expect_one_event(input string name, input logic [31:0] expected);
        logic [31:0] d;
        logic        err;
        wait_for_status("not-empty", 32'h1, 32'h1, 100);
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value({name, " STATUS.level"}, 32'd1, (d >> 8) & 32'hFF);
        apb_read(ps2_pkg::REG_DATA, d, err);
        check_value({name, " DATA"}, expected, d);
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value({name, " STATUS.not_empty"}, 32'd0, d & 32'h1);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s with %0d errors", name, errors - errors_before);
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic reset_and_disable();
        logic [31:0] d;
        logic        err;
        int          e0;
        e0 = errors;
        apb_read(ps2_pkg::REG_CTRL, d, err);
        check_value("CTRL", 32'd0, d);
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS", 32'd0, d);
        @(negedge clk);
        check_value("irq", 32'd0, {31'd0, irq});
        // Receiver still disabled, frame must vanish
        send_frame(8'h1C, 1'b1, 1'b1, 11);
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS.not_empty", 32'd0, d & 32'h1);
        report_test("reset and disable", e0);
    endtask

    task automatic make_codes_in_order();
        logic [7:0]  codes [4];
        logic [31:0] d;
        logic        err;
        int          e0;
        e0 = errors;
        apb_write(ps2_pkg::REG_CTRL, 32'h1);
        for (int i = 0; i < 4; i++) begin
            next_code(codes[i]);
            send_frame(codes[i], 1'b1, 1'b1, 11);
        end
        wait_for_status("level 4", 32'hFF00, 32'h0400, 100);
        // Queue holds events but irq_en is still clear
        @(negedge clk);
        check_value("irq with irq_en clear", 32'd0, {31'd0, irq});
        for (int i = 0; i < 4; i++) begin
            apb_read(ps2_pkg::REG_DATA, d, err);
            check_value("DATA", key_word(1'b0, 1'b0, codes[i]), d);
        end
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS", 32'd0, d);
        report_test("make codes in order", e0);
    endtask

    task automatic prefix_events();
        int e0;
        e0 = errors;
        send_frame(8'hE0, 1'b1, 1'b1, 11);
        send_frame(8'h74, 1'b1, 1'b1, 11);
        expect_one_event("E0 74", key_word(1'b0, 1'b1, 8'h74));
        send_frame(8'hF0, 1'b1, 1'b1, 11);
        send_frame(8'h1C, 1'b1, 1'b1, 11);
        expect_one_event("F0 1C", key_word(1'b1, 1'b0, 8'h1C));
        send_frame(8'hE0, 1'b1, 1'b1, 11);
        send_frame(8'hF0, 1'b1, 1'b1, 11);
        send_frame(8'h74, 1'b1, 1'b1, 11);
        expect_one_event("E0 F0 74", key_word(1'b1, 1'b1, 8'h74));
        report_test("prefixes", e0);
    endtask

    task automatic error_frames();
        logic [31:0] d;
        logic        err;
        int          e0;
        e0 = errors;
        // Wrong parity
        send_frame(8'h2A, 1'b0, 1'b1, 11);
        wait_for_status("parity error", 32'h4, 32'h4, 100);
        apb_read(ps2_pkg::REG_ERRCNT, d, err);
        check_value("ERRCNT", 32'd1, d);
        // Parity flag only, nothing queued
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS after parity error", 32'h4, d);
        // Stop bit low
        send_frame(8'h2A, 1'b1, 1'b0, 11);
        wait_for_status("frame error", 32'h8, 32'h8, 100);
        apb_read(ps2_pkg::REG_ERRCNT, d, err);
        check_value("ERRCNT", 32'd2, d);
        apb_write(ps2_pkg::REG_STATUS, 32'hE);
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS after clear", 32'd0, d);
        // Frame cut off after 5 bits, idle timeout abandons it
        send_frame(8'h55, 1'b1, 1'b1, 5);
        wait_for_status("frame error after timeout", 32'h8, 32'h8, 1500);
        apb_read(ps2_pkg::REG_ERRCNT, d, err);
        check_value("ERRCNT", 32'd3, d);
        send_frame(8'h33, 1'b1, 1'b1, 11);
        wait_for_status("not-empty", 32'h1, 32'h1, 100);
        apb_read(ps2_pkg::REG_DATA, d, err);
        check_value("DATA", key_word(1'b0, 1'b0, 8'h33), d);
        // Clear sticky bits and the counter
        apb_write(ps2_pkg::REG_STATUS, 32'hE);
        apb_write(ps2_pkg::REG_ERRCNT, 32'h0);
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS after clear", 32'd0, d);
        apb_read(ps2_pkg::REG_ERRCNT, d, err);
        check_value("ERRCNT after clear", 32'd0, d);
        report_test("error frames", e0);
    endtask

    task automatic overflow_and_irq();
        logic [7:0]  codes [10];
        logic [31:0] d;
        logic        err;
        int          e0;
        e0 = errors;
        apb_write(ps2_pkg::REG_CTRL, 32'h3);
        next_code(codes[0]);
        send_frame(codes[0], 1'b1, 1'b1, 11);
        wait_for_status("not-empty", 32'h1, 32'h1, 100);
        wait_irq(1'b1, 10);
        // Two more than the queue holds
        for (int i = 1; i < 10; i++) begin
            next_code(codes[i]);
            send_frame(codes[i], 1'b1, 1'b1, 11);
        end
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS full with overflow", 32'h0803, d);
        for (int i = 0; i < 8; i++) begin
            apb_read(ps2_pkg::REG_DATA, d, err);
            check_value("DATA", key_word(1'b0, 1'b0, codes[i]), d);
        end
        wait_irq(1'b0, 10);
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS drained", 32'h2, d);
        apb_write(ps2_pkg::REG_STATUS, 32'h2);
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS after clear", 32'd0, d);
        report_test("overflow and interrupt", e0);
    endtask

    task automatic bus_errors();
        logic [31:0] d;
        logic        err;
        int          e0;
        e0 = errors;
        // Offsets outside the register map
        apb_read(4'h2, d, err);
        check_value("pslverr at 0x2", 32'd1, {31'd0, err});
        apb_read(4'h7, d, err);
        check_value("pslverr at 0x7", 32'd1, {31'd0, err});
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("pslverr at STATUS", 32'd0, {31'd0, err});
        check_value("pready", 32'd1, {31'd0, pready});
        // Empty queue read
        apb_read(ps2_pkg::REG_DATA, d, err);
        check_value("DATA while empty", 32'd0, d);
        check_value("pslverr at DATA", 32'd0, {31'd0, err});
        apb_read(ps2_pkg::REG_STATUS, d, err);
        check_value("STATUS.level", 32'd0, (d >> 8) & 32'hFF);
        report_test("bus errors", e0);
    endtask

    // ------------------------------------------------------------------------
    // Sequence and summary
    // ------------------------------------------------------------------------
    initial begin
        seed       = 32'h623c;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        rst      <= 1'b1;
        ps2_clk  <= 1'b1;
        ps2_data <= 1'b1;
        paddr    <= '0;
        psel     <= 1'b0;
        penable  <= 1'b0;
        pwrite   <= 1'b0;
        pwdata   <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_and_disable();
        make_codes_in_order();
        prefix_events();
        error_frames();
        overflow_and_irq();
        bus_errors();
        $display("Tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Hard stop if a test hangs
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: hw/ps2_kbd_top.sv
`timescale 1ns/1ps

module ps2_kbd_top #(
    parameter int FIFO_DEPTH   = 8,
    parameter int IDLE_TIMEOUT = 2000
) (
    input  logic               clk,
    input  logic               rst,
    // PS/2 device lines, input only
    input  logic               ps2_clk,
    input  logic               ps2_data,
    // APB slave
    input  ps2_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  ps2_pkg::apb_data_t pwdata,
    output ps2_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               irq
);

    logic                enable;
    logic                ev_valid;
    ps2_pkg::key_event_t ev_data;
    logic                parity_seen;
    logic                frame_seen;

    ps2_byte_if                           byte_bus ();
    ps2_evq_if #(.FIFO_DEPTH(FIFO_DEPTH)) evq ();

    // ------------------------------------------------------------------------
    // Receive path: frame capture, prefix decode, event queue
    // ------------------------------------------------------------------------
    ps2_frame_rx #(.IDLE_TIMEOUT(IDLE_TIMEOUT)) frame_rx0 (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_data(ps2_data),
        .rx_byte (byte_bus.rx)
    );

    ps2_scan_decoder decoder0 (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .rx_byte    (byte_bus.dec),
        .ev_valid   (ev_valid),
        .ev_data    (ev_data),
        .parity_seen(parity_seen),
        .frame_seen (frame_seen)
    );

    ps2_event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
        .clk     (clk),
        .rst     (rst),
        .ev_valid(ev_valid),
        .ev_data (ev_data),
        .q       (evq.fifo)
    );

    // Host registers and interrupt
    ps2_apb_regs #(.FIFO_DEPTH(FIFO_DEPTH)) regs0 (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .parity_seen(parity_seen),
        .frame_seen (frame_seen),
        .enable     (enable),
        .irq        (irq),
        .q          (evq.host)
    );

endmodule

// File: hw/ps2_apb_regs.sv
`timescale 1ns/1ps

module ps2_apb_regs #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  ps2_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  ps2_pkg::apb_data_t pwdata,
    output ps2_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic               parity_seen,
    input  logic               frame_seen,
    output logic               enable,
    output logic               irq,
    ps2_evq_if.host            q
);

    // Level field as it appears in STATUS
    localparam int LW = $clog2(FIFO_DEPTH) + 1;

    logic       access;
    logic       wr;
    logic       rd;
    logic       addr_ok;
    logic       irq_en;
    logic       par_err;
    logic       frm_err;
    logic [7:0] err_cnt;
    logic [7:0] level8;

    // ------------------------------------------------------------------------
    // Bus decode
    // ------------------------------------------------------------------------
    assign access  = psel & penable;
    assign wr      = access & pwrite;
    assign rd      = access & ~pwrite;
    assign addr_ok = (paddr == ps2_pkg::REG_CTRL)   || (paddr == ps2_pkg::REG_STATUS) ||
                     (paddr == ps2_pkg::REG_DATA)   || (paddr == ps2_pkg::REG_ERRCNT);

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access & ~addr_ok;

    // DATA read pops the head in the access cycle
    assign q.pop       = rd & (paddr == ps2_pkg::REG_DATA) & ~q.empty;
    // W1C on STATUS overflow goes straight to the queue
    assign q.ovf_clear = wr & (paddr == ps2_pkg::REG_STATUS) & pwdata[ps2_pkg::ST_OVF_BIT];

    // Zero-extend the queue level into the 8-bit STATUS field
    assign level8 = {{(8 - LW){1'b0}}, q.level};

    // ------------------------------------------------------------------------
    // Control and error registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            enable  <= 1'b0;
            irq_en  <= 1'b0;
            par_err <= 1'b0;
            frm_err <= 1'b0;
            err_cnt <= 8'd0;
            irq     <= 1'b0;
        end else begin
            if (wr && paddr == ps2_pkg::REG_CTRL) begin
                enable <= pwdata[ps2_pkg::CTRL_EN_BIT];
                irq_en <= pwdata[ps2_pkg::CTRL_IRQ_EN_BIT];
            end
            // Sticky error flags, a new error beats the clear
            if (parity_seen) begin
                par_err <= 1'b1;
            end else if (wr && paddr == ps2_pkg::REG_STATUS && pwdata[ps2_pkg::ST_PAR_BIT]) begin
                par_err <= 1'b0;
            end
            if (frame_seen) begin
                frm_err <= 1'b1;
            end else if (wr && paddr == ps2_pkg::REG_STATUS && pwdata[ps2_pkg::ST_FRM_BIT]) begin
                frm_err <= 1'b0;
            end
            // One count per rejected frame, saturating
            if (wr && paddr == ps2_pkg::REG_ERRCNT) begin
                err_cnt <= 8'd0;
            end else if ((parity_seen || frame_seen) && err_cnt != 8'hFF) begin
                err_cnt <= err_cnt + 8'd1;
            end
            irq <= irq_en & ~q.empty;
        end
    end

    // ------------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------------
    always_comb begin
        prdata = '0;
        case (paddr)
            ps2_pkg::REG_CTRL: begin
                prdata[ps2_pkg::CTRL_EN_BIT]     = enable;
                prdata[ps2_pkg::CTRL_IRQ_EN_BIT] = irq_en;
            end
            ps2_pkg::REG_STATUS: begin
                prdata[ps2_pkg::ST_NE_BIT]  = ~q.empty;
                prdata[ps2_pkg::ST_OVF_BIT] = q.overflow;
                prdata[ps2_pkg::ST_PAR_BIT] = par_err;
                prdata[ps2_pkg::ST_FRM_BIT] = frm_err;
                prdata[ps2_pkg::ST_LVL_LSB +: 8] = level8;
            end
            // Empty queue reads as zero
            ps2_pkg::REG_DATA:   prdata[9:0] = q.empty ? '0 : q.head;
            ps2_pkg::REG_ERRCNT: prdata[7:0] = err_cnt;
            default:             prdata = '0;
        endcase
    end

endmodule

// File: hw/ps2_event_fifo.sv
`timescale 1ns/1ps

module ps2_event_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ev_valid,
    input  ps2_pkg::key_event_t ev_data,
    ps2_evq_if.fifo             q
);

    // Pointer width, depth is a power of two so pointers wrap by themselves
    localparam int AW = $clog2(FIFO_DEPTH);

    ps2_pkg::key_event_t mem [FIFO_DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [AW:0]         level;
    logic                ovf;
    logic                full;
    logic                do_wr;
    logic                do_rd;

    assign full  = (level == (AW + 1)'(FIFO_DEPTH));
    assign do_wr = ev_valid & ~full;
    // Pop on an empty queue is ignored
    assign do_rd = q.pop & (level != '0);

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= ev_data;
        end
    end

    // Pointers, level and sticky overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd) begin
                level <= level + 1'b1;
            end else if (do_rd && !do_wr) begin
                level <= level - 1'b1;
            end
            // A new drop wins over a clear in the same cycle
            if (ev_valid && full) begin
                ovf <= 1'b1;
            end else if (q.ovf_clear) begin
                ovf <= 1'b0;
            end
        end
    end

    assign q.head     = mem[rd_ptr];
    assign q.empty    = (level == '0);
    assign q.level    = level;
    assign q.overflow = ovf;

endmodule

// File: hw/ps2_scan_decoder.sv
`timescale 1ns/1ps

module ps2_scan_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    ps2_byte_if.dec             rx_byte,
    output logic                ev_valid,
    output ps2_pkg::key_event_t ev_data,
    output logic                parity_seen,
    output logic                frame_seen
);

    ps2_pkg::dec_state_t state;
    ps2_pkg::key_event_t ev_next;
    logic                good_byte;
    logic                is_ext;
    logic                is_brk;

    // Accepted frame, only while the receiver is enabled
    assign good_byte = enable & rx_byte.valid & ~rx_byte.parity_err & ~rx_byte.frame_err;
    assign is_ext    = (rx_byte.data == ps2_pkg::PFX_EXT);
    assign is_brk    = (rx_byte.data == ps2_pkg::PFX_BRK);

    // Event word from the byte and the flags collected so far
    always_comb begin
        ev_next                      = '0;
        ev_next[7:0]                 = rx_byte.data;
        ev_next[ps2_pkg::EV_EXT_BIT] = (state == ps2_pkg::GOT_EXT) ||
                                       (state == ps2_pkg::GOT_EXT_BRK);
        ev_next[ps2_pkg::EV_REL_BIT] = (state == ps2_pkg::GOT_BRK) ||
                                       (state == ps2_pkg::GOT_EXT_BRK);
    end

    // ------------------------------------------------------------------------
    // Prefix FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ps2_pkg::IDLE;
            ev_valid    <= 1'b0;
            parity_seen <= 1'b0;
            frame_seen  <= 1'b0;
        end else begin
            ev_valid    <= 1'b0;
            parity_seen <= 1'b0;
            frame_seen  <= 1'b0;
            if (!enable) begin
                // Disabled, drop everything
                state <= ps2_pkg::IDLE;
            end else if (rx_byte.valid) begin
                if (rx_byte.parity_err || rx_byte.frame_err) begin
                    // Bad frame breaks any pending prefix sequence
                    state       <= ps2_pkg::IDLE;
                    parity_seen <= rx_byte.parity_err;
                    frame_seen  <= rx_byte.frame_err;
                end else if (is_ext) begin
                    state <= ps2_pkg::GOT_EXT;
                end else if (is_brk) begin
                    state <= (state == ps2_pkg::GOT_EXT) ? ps2_pkg::GOT_EXT_BRK
                                                         : ps2_pkg::GOT_BRK;
                end else begin
                    ev_valid <= 1'b1;
                    state    <= ps2_pkg::IDLE;
                end
            end
        end
    end

    // Payload register, loaded with each final code byte
    always_ff @(posedge clk) begin
        if (good_byte && !is_ext && !is_brk) begin
            ev_data <= ev_next;
        end
    end

endmodule

// File: hw/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx #(
    parameter int IDLE_TIMEOUT = 2000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ps2_clk,
    input  logic        ps2_data,
    ps2_byte_if.rx      rx_byte
);

    // Timeout counter wide enough for IDLE_TIMEOUT
    localparam int TW = $clog2(IDLE_TIMEOUT + 1);

    // ------------------------------------------------------------------------
    // Input synchronizers and edge detect
    // ------------------------------------------------------------------------

    // Both lines idle high, so all flops preset to 1
    logic clk_s1;
    logic clk_s2;
    logic clk_d;
    logic dat_s1;
    logic dat_s2;
    logic fall;

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_s1 <= 1'b1;
            clk_s2 <= 1'b1;
            clk_d  <= 1'b1;
            dat_s1 <= 1'b1;
            dat_s2 <= 1'b1;
        end else begin
            clk_s1 <= ps2_clk;
            clk_s2 <= clk_s1;
            clk_d  <= clk_s2;
            dat_s1 <= ps2_data;
            dat_s2 <= dat_s1;
        end
    end

    // High for one cycle after the synchronized clock drops
    assign fall = clk_d & ~clk_s2;

    // ------------------------------------------------------------------------
    // Frame capture
    // ------------------------------------------------------------------------

    // Bits 0..9 of the frame, LSB first, start bit ends up in shreg[0]
    logic [9:0]    shreg;
    logic [3:0]    bit_cnt;
    logic [TW-1:0] idle_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt       <= 4'd0;
            idle_cnt      <= '0;
            rx_byte.valid <= 1'b0;
        end else begin
            rx_byte.valid <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    // Stop bit arrives now, frame complete
                    bit_cnt       <= 4'd0;
                    rx_byte.valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                // Partial frame waiting for the next fall
                if (idle_cnt == TW'(IDLE_TIMEOUT - 1)) begin
                    bit_cnt       <= 4'd0;
                    idle_cnt      <= '0;
                    rx_byte.valid <= 1'b1;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end else begin
                idle_cnt <= '0;
            end
        end
    end

    // Shift register and result payload
    always_ff @(posedge clk) begin
        if (fall) begin
            if (bit_cnt == 4'd10) begin
                rx_byte.data       <= shreg[8:1];
                // Odd parity over data plus parity bit
                rx_byte.parity_err <= ~(^shreg[9:1]);
                // Start must be 0, stop (current bit) must be 1
                rx_byte.frame_err  <= shreg[0] | ~dat_s2;
            end else begin
                shreg <= {dat_s2, shreg[9:1]};
            end
        end else if (bit_cnt != 4'd0 && idle_cnt == TW'(IDLE_TIMEOUT - 1)) begin
            // Abandoned frame
            rx_byte.data       <= shreg[8:1];
            rx_byte.parity_err <= 1'b0;
            rx_byte.frame_err  <= 1'b1;
        end
    end

endmodule

// File: hw/ps2_ifs.sv
`timescale 1ns/1ps

// Frame result from the receiver to the scan decoder
interface ps2_byte_if;

    // One-cycle strobe per frame
    logic                valid;
    // Payload, only meaningful with valid
    ps2_pkg::ps2_byte_t  data;
    logic                parity_err;
    logic                frame_err;

    modport rx  (output valid, data, parity_err, frame_err);
    modport dec (input  valid, data, parity_err, frame_err);

endinterface

// Event queue as seen by the register block
interface ps2_evq_if #(
    parameter int FIFO_DEPTH = 8
);

    // Host side handshake
    logic                          pop;
    logic                          ovf_clear;
    // Queue state, head valid whenever not empty
    ps2_pkg::key_event_t           head;
    logic                          empty;
    logic [$clog2(FIFO_DEPTH):0]   level;
    logic                          overflow;

    modport fifo (input  pop, ovf_clear, output head, empty, level, overflow);
    modport host (output pop, ovf_clear, input  head, empty, level, overflow);

endinterface

// File: hw/ps2_pkg.sv
package ps2_pkg;

    // ------------------------------------------------------------------------
    // Data widths
    // ------------------------------------------------------------------------

    // One data byte out of a PS/2 frame
    typedef logic [7:0] ps2_byte_t;

    // Queued key event {release, extended, code}
    typedef logic [9:0] key_event_t;

    // APB byte address and data
    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Flag positions inside key_event_t
    localparam int EV_EXT_BIT = 8;
    localparam int EV_REL_BIT = 9;

    // Scan-code prefixes, set 2
    localparam ps2_byte_t PFX_EXT = 8'hE0;
    localparam ps2_byte_t PFX_BRK = 8'hF0;

    // ------------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------------
    localparam apb_addr_t REG_CTRL   = 4'h0;
    localparam apb_addr_t REG_STATUS = 4'h4;
    localparam apb_addr_t REG_DATA   = 4'h8;
    localparam apb_addr_t REG_ERRCNT = 4'hC;

    // CTRL fields
    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_IRQ_EN_BIT = 1;

    // STATUS fields, level sits in 15..8
    localparam int ST_NE_BIT   = 0;
    localparam int ST_OVF_BIT  = 1;
    localparam int ST_PAR_BIT  = 2;
    localparam int ST_FRM_BIT  = 3;
    localparam int ST_LVL_LSB  = 8;

    // Prefix tracking states of the scan decoder
    typedef enum logic [1:0] {
        IDLE,
        GOT_EXT,
        GOT_BRK,
        GOT_EXT_BRK
    } dec_state_t;

endpackage
